// File: worksheet_top.f
+incdir+logic
logic/worksheet_pkg.sv
logic/arg_port_if.sv
logic/input_decoder.sv
logic/arg_store_arbiter.sv
logic/column_reducer.sv
logic/worksheet_top.sv
test/worksheet_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the worksheet testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module worksheet_tb \
    -f worksheet_top.f

sim_out=$(./obj_dir/Vworksheet_tb)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qF '*** TEST PASSED ***'; then
    exit 0
else
    exit 1
fi

// File: test/worksheet_tb.sv
`timescale 1ns/1ps
`default_nettype none

module worksheet_tb
    import worksheet_pkg::*;
();

    localparam int NUM_ENTRIES = 4;
    localparam int MAX_COLS    = 16;
    localparam int WAIT_LIMIT  = 2000;  // cycles per wait.

    logic       clk = 1'b0;
    logic       rst_n;
    logic       byte_valid;
    logic [7:0] byte_data;

    logic       column_valid;
    col_t       column_index;
    result_t    column_result;
    result_t    total;
    logic       busy;

    // ########################################
    // stimulus table
    // ########################################

    string   ws_text   [NUM_ENTRIES];
    int      exp_cols  [NUM_ENTRIES];
    result_t exp_res   [NUM_ENTRIES][MAX_COLS];
    result_t exp_total [NUM_ENTRIES];

    logic [31:0] rng_state;
    int          cur_entry;
    int          pulse_cnt;
    result_t     running_total;
    int          entry_errors;
    int          error_count;
    int          check_count;

    always #50 clk = ~clk;

    worksheet_top u_worksheet_top (
        .clk           (clk),
        .rst_n         (rst_n),
        .byte_valid    (byte_valid),
        .byte_data     (byte_data),
        .column_valid  (column_valid),
        .column_index  (column_index),
        .column_result (column_result),
        .total         (total),
        .busy          (busy)
    );

    task automatic load_table();
        ws_text[0]    = "12 3 4\n5 6 7\n+ * +\n";
        exp_cols[0]   = 3;
        exp_res[0][0] = 64'd17;
        exp_res[0][1] = 64'd18;
        exp_res[0][2] = 64'd11;
        exp_total[0]  = 64'd46;

        // leading and repeated spaces.
        ws_text[1]    = "  123   45  6\n 7    890 12\n 10  2  300\n*   +  *\n";
        exp_cols[1]   = 3;
        exp_res[1][0] = 64'd8610;
        exp_res[1][1] = 64'd937;
        exp_res[1][2] = 64'd21600;
        exp_total[1]  = 64'd31147;

        // 65535 to the fifth wraps at 64 bits.
        ws_text[2]    = "65535 1\n65535 2\n65535 3\n65535 4\n65535 5\n* *\n";
        exp_cols[2]   = 2;
        exp_res[2][0] = 64'h0009_fff6_0004_ffff;
        exp_res[2][1] = 64'd120;
        exp_total[2]  = 64'h0009_fff6_0005_0077;

        ws_text[3]    = "0 9 100 7\n8 0 200 7\n* + + *\n";
        exp_cols[3]   = 4;
        exp_res[3][0] = 64'd0;
        exp_res[3][1] = 64'd9;
        exp_res[3][2] = 64'd300;
        exp_res[3][3] = 64'd49;
        exp_total[3]  = 64'd358;
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic compare_value(input string name, input result_t got, input result_t exp);
        check_count++;
        assert (got === exp) else begin
            $display("CHECK FAILED at %0t ns: %s got %0d expected %0d",
                     $time, name, got, exp);
            entry_errors++;
        end
    endtask

    // ########################################
    // driver and waits
    // ########################################

    task automatic apply_reset();
        @(posedge clk);
        rst_n      <= 1'b0;
        byte_valid <= 1'b0;
        byte_data  <= 8'h00;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic send_text(input string text);
        int gap;
        for (int i = 0; i < text.len(); i++) begin
            rng_state = xorshift32(rng_state);
            gap = int'(rng_state[1:0]);  // 0 to 3 idle cycles.
            repeat (gap) begin
                @(posedge clk);
                byte_valid <= 1'b0;
            end
            @(posedge clk);
            byte_valid <= 1'b1;
            byte_data  <= text[i];
        end
        @(posedge clk);
        byte_valid <= 1'b0;
    endtask

    task automatic wait_for_busy(input logic level, output bit timed_out);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while ((busy !== level) && (cycles < WAIT_LIMIT)) begin
            @(negedge clk);
            cycles++;
        end
        timed_out = (busy !== level);
        assert (!timed_out) else begin
            $display("timeout: busy did not go to %0b within %0d cycles at %0t ns",
                     level, WAIT_LIMIT, $time);
            entry_errors++;
        end
    endtask

    // ########################################
    // result monitor
    // ########################################

    task automatic score_column();
        assert (pulse_cnt < exp_cols[cur_entry]) else begin
            $display("entry %0d: extra column pulse for column %0d at %0t ns",
                     cur_entry, column_index, $time);
            entry_errors++;
        end
        if (pulse_cnt < exp_cols[cur_entry]) begin
            running_total = running_total + exp_res[cur_entry][pulse_cnt];
            compare_value("column_index", result_t'(column_index), result_t'(pulse_cnt));
            compare_value("column_result", column_result, exp_res[cur_entry][pulse_cnt]);
            compare_value("total", total, running_total);  // includes this column.
        end
        pulse_cnt++;
    endtask

    always @(negedge clk) begin
        if (rst_n && column_valid) begin
            score_column();
        end
    end

    task automatic run_entry(input int e);
        bit timed_out;
        cur_entry     = e;
        pulse_cnt     = 0;
        running_total = '0;
        entry_errors  = 0;
        apply_reset();
        @(negedge clk);
        compare_value("total", total, '0);
        compare_value("busy", result_t'(busy), '0);
        compare_value("column_valid", result_t'(column_valid), '0);

        send_text(ws_text[e]);
        wait_for_busy(1'b1, timed_out);
        if (!timed_out) begin
            wait_for_busy(1'b0, timed_out);
        end
        @(negedge clk);

        assert (pulse_cnt == exp_cols[e]) else begin
            $display("entry %0d: saw %0d column pulses but expected %0d",
                     e, pulse_cnt, exp_cols[e]);
            entry_errors++;
        end
        compare_value("total", total, exp_total[e]);

        if (entry_errors == 0) begin
            $display("entry %0d ok: %0d columns, total %0d", e, pulse_cnt, total);
        end else begin
            $display("entry %0d had %0d errors", e, entry_errors);
        end
        error_count += entry_errors;
    endtask

    // ########################################
    // main sequence
    // ########################################

    initial begin
        rst_n        = 1'b0;
        byte_valid   = 1'b0;
        byte_data    = 8'h00;
        rng_state    = 32'h50bd_b21f;
        cur_entry    = 0;
        pulse_cnt    = 0;
        entry_errors = 0;
        error_count  = 0;
        check_count  = 0;
        load_table();

        for (int e = 0; e < NUM_ENTRIES; e++) begin
            run_entry(e);
        end

        $display("%0d entries, %0d checks, %0d errors", NUM_ENTRIES, check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/worksheet_top.sv
`timescale 1ns/1ps
`default_nettype none

module worksheet_top
    import worksheet_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic       byte_valid,
    input  logic [7:0] byte_data,

    output logic       column_valid,
    output col_t       column_index,
    output result_t    column_result,
    output result_t    total,
    output logic       busy
);

    // ########################################
    // store ports and operator pulse
    // ########################################

    arg_port_if dec_if ();
    arg_port_if red_if ();

    logic op_valid;
    op_t  op_kind;
    col_t op_col;
    row_t op_rows;

    input_decoder u_input_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .byte_valid (byte_valid),
        .byte_data  (byte_data),
        .store      (dec_if.requester),
        .op_valid   (op_valid),
        .op_kind    (op_kind),
        .op_col     (op_col),
        .op_rows    (op_rows)
    );

    arg_store_arbiter u_arg_store_arbiter (
        .clk      (clk),
        .rst_n    (rst_n),
        .dec_port (dec_if.arbiter),
        .red_port (red_if.arbiter)
    );

    column_reducer u_column_reducer (
        .clk           (clk),
        .rst_n         (rst_n),
        .op_valid      (op_valid),
        .op_kind       (op_kind),
        .op_col        (op_col),
        .op_rows       (op_rows),
        .store         (red_if.requester),
        .column_valid  (column_valid),
        .column_index  (column_index),
        .column_result (column_result),
        .total         (total),
        .busy          (busy)
    );

endmodule

`default_nettype wire

// File: logic/column_reducer.sv
`timescale 1ns/1ps
`default_nettype none

`include "worksheet_cfg.svh"

module column_reducer
    import worksheet_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,

    input  logic    op_valid,
    input  op_t     op_kind,
    input  col_t    op_col,
    input  row_t    op_rows,

    arg_port_if.requester store,

    output logic    column_valid,
    output col_t    column_index,
    output result_t column_result,
    output result_t total,
    output logic    busy
);

    localparam int DEPTH = `WS_OP_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    // ########################################
    // operator queue
    // ########################################

    op_t  q_kind [DEPTH];
    col_t q_col  [DEPTH];
    row_t q_rows [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push;
    logic             pop;

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,
        S_WAIT,
        S_DONE
    } state_t;

    state_t  state;
    op_t     cur_kind;
    col_t    cur_col;
    row_t    cur_rows;
    row_t    row_idx;
    result_t acc;
    result_t fold_value;

    assign push = op_valid && (count != (PTR_W+1)'(DEPTH));  // full queue drops.
    assign pop  = (state == S_IDLE) && (count != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            q_kind[wr_ptr] <= op_kind;
            q_col[wr_ptr]  <= op_col;
            q_rows[wr_ptr] <= op_rows;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // ########################################
    // column fold
    // ########################################

    assign fold_value = (cur_kind == OP_MULT) ? acc * result_t'(store.rdata)
                                              : acc + result_t'(store.rdata);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= S_IDLE;
            row_idx      <= '0;
            column_valid <= 1'b0;
            total        <= '0;
        end else begin
            column_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (pop) begin
                        row_idx <= '0;
                        state   <= (q_rows[rd_ptr] == '0) ? S_DONE : S_REQ;
                    end
                end
                S_REQ: begin
                    if (store.grant) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    row_idx <= row_idx + 1'b1;
                    state   <= (row_idx == cur_rows - 1'b1) ? S_DONE : S_REQ;
                end
                default: begin
                    column_valid <= 1'b1;
                    total        <= total + acc;
                    state        <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            cur_kind <= q_kind[rd_ptr];
            cur_col  <= q_col[rd_ptr];
            cur_rows <= q_rows[rd_ptr];
            acc      <= (q_kind[rd_ptr] == OP_MULT) ? result_t'(1) : '0;  // seed.
        end else if (state == S_WAIT) begin
            acc <= fold_value;
        end
        if (state == S_DONE) begin
            column_index  <= cur_col;
            column_result <= acc;
        end
    end

    assign store.req   = (state == S_REQ);
    assign store.we    = 1'b0;
    assign store.addr  = {cur_col, row_idx};
    assign store.wdata = '0;  // read-only requester.

    assign busy = (count != '0) || (state != S_IDLE);

endmodule

`default_nettype wire

// File: logic/arg_store_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module arg_store_arbiter
    import worksheet_pkg::*;
(
    input  logic clk,
    input  logic rst_n,

    arg_port_if.arbiter dec_port,
    arg_port_if.arbiter red_port
);

    localparam int STORE_WORDS = 2 ** $bits(store_addr_t);

    arg_t mem [STORE_WORDS];

    logic        sel_valid;
    logic        sel_we;
    store_addr_t sel_addr;
    arg_t        sel_wdata;

    // ########################################
    // fixed priority grant
    // ########################################

    assign dec_port.grant = dec_port.req;
    assign red_port.grant = red_port.req && !dec_port.req;  // waits out decoder writes.

    assign sel_valid = dec_port.grant || red_port.grant;
    assign sel_we    = dec_port.grant ? dec_port.we    : red_port.we;
    assign sel_addr  = dec_port.grant ? dec_port.addr  : red_port.addr;
    assign sel_wdata = dec_port.grant ? dec_port.wdata : red_port.wdata;

    // ########################################
    // store memory
    // ########################################

    always_ff @(posedge clk) begin
        if (sel_valid && sel_we) begin
            mem[sel_addr] <= sel_wdata;
        end
    end

    // read data lands on the port that was granted the read.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_port.rdata <= '0;
            red_port.rdata <= '0;
        end else begin
            if (dec_port.grant && !dec_port.we) begin
                dec_port.rdata <= mem[sel_addr];
            end
            if (red_port.grant && !red_port.we) begin
                red_port.rdata <= mem[sel_addr];
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/input_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module input_decoder
    import worksheet_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    input  logic       byte_valid,
    input  logic [7:0] byte_data,

    arg_port_if.requester store,

    output logic       op_valid,
    output op_t        op_kind,
    output col_t       op_col,
    output row_t       op_rows
);

    row_t row_cnt;
    col_t col_cnt;
    arg_t acc;

    logic char_is_digit;
    logic char_is_text;
    logic prev_was_digit;
    logic prev_was_text;

    assign char_is_digit = (byte_data >= ZERO_CHAR) && (byte_data <= NINE_CHAR);
    assign char_is_text  = char_is_digit ||
                           (byte_data == ADD_CHAR) || (byte_data == MULT_CHAR);

    // ########################################
    // position tracking
    // ########################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_cnt        <= '0;
            col_cnt        <= '0;
            prev_was_digit <= 1'b0;
            prev_was_text  <= 1'b0;
        end else if (byte_valid) begin
            prev_was_digit <= char_is_digit;
            prev_was_text  <= char_is_text;
            if (byte_data == SPACE_CHAR) begin
                if (prev_was_text) begin
                    col_cnt <= col_cnt + 1'b1;  // first space after a field.
                end
            end else if (byte_data == LF_CHAR) begin
                col_cnt <= '0;
                row_cnt <= row_cnt + 1'b1;
            end
        end
    end

    // decimal accumulation restarts on the first digit of a field.
    always_ff @(posedge clk) begin
        if (byte_valid && char_is_digit) begin
            if (prev_was_digit) begin
                acc <= acc * arg_t'(10) + arg_t'(byte_data[3:0]);
            end else begin
                acc <= arg_t'(byte_data[3:0]);
            end
        end
    end

    // ########################################
    // argument writes and operator pulses
    // ########################################

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            store.req <= 1'b0;
            op_valid  <= 1'b0;
        end else begin
            store.req <= byte_valid && !char_is_digit && prev_was_digit;
            op_valid  <= byte_valid &&
                         ((byte_data == ADD_CHAR) || (byte_data == MULT_CHAR));
        end
    end

    // counters still hold the position of the field being closed.
    always_ff @(posedge clk) begin
        if (byte_valid) begin
            store.addr  <= {col_cnt, row_cnt};
            store.wdata <= acc;
            op_kind     <= (byte_data == MULT_CHAR) ? OP_MULT : OP_ADD;
            op_col      <= col_cnt;
            op_rows     <= row_cnt;  // operator row index.
        end
    end

    assign store.we = store.req;  // write-only requester.

endmodule

`default_nettype wire

// File: logic/arg_port_if.sv
`timescale 1ns/1ps
`default_nettype none

interface arg_port_if
    import worksheet_pkg::*;
();

    logic        req;    // held by requester until granted.
    logic        we;
    store_addr_t addr;
    arg_t        wdata;

    logic        grant;  // same cycle as req.
    arg_t        rdata;  // one cycle after a granted read.

    modport requester (
        output req,
        output we,
        output addr,
        output wdata,
        input  grant,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output grant,
        output rdata
    );

endinterface

`default_nettype wire

// File: logic/worksheet_pkg.sv
`default_nettype none

package worksheet_pkg;

    `include "worksheet_cfg.svh"

    // ########################################
    // input characters
    // ########################################

    typedef enum byte {
        ZERO_CHAR  = 8'h30,
        NINE_CHAR  = 8'h39,
        SPACE_CHAR = 8'h20,
        LF_CHAR    = 8'h0A,
        ADD_CHAR   = 8'h2B,
        MULT_CHAR  = 8'h2A
    } char_t;

    // ########################################
    // datapath types
    // ########################################

    typedef logic [`WS_ROW_WIDTH-1:0] row_t;
    typedef logic [`WS_COL_WIDTH-1:0] col_t;
    typedef logic [`WS_DATA_WIDTH-1:0] arg_t;
    typedef logic [`WS_RESULT_WIDTH-1:0] result_t;

    // column in the upper bits and row in the lower.
    typedef logic [`WS_COL_WIDTH+`WS_ROW_WIDTH-1:0] store_addr_t;

    typedef enum logic {
        OP_ADD  = 1'b0,
        OP_MULT = 1'b1
    } op_t;

endpackage

`default_nettype wire

// File: logic/worksheet_cfg.svh
`ifndef WORKSHEET_CFG_SVH
`define WORKSHEET_CFG_SVH

// ########################################
// worksheet geometry
// ########################################

// row index including the operator row.
`define WS_ROW_WIDTH 3

// up to 16 columns.
`define WS_COL_WIDTH 4

// ########################################
// datapath
// ########################################

`define WS_DATA_WIDTH 16       // one argument.
`define WS_RESULT_WIDTH 64     // column result and grand total.
`define WS_OP_QUEUE_DEPTH 16   // pending operators.

`endif
